//--- verilog/wide_mem_pkg.sv
/* wide memory port constants */

package wide_mem_pkg;

  // the accelerator port is four 32-bit lanes wide
  localparam int unsigned NB_LANES = 4;

  // defaults handed down by the top level
  localparam int unsigned NB_BANKS_DEF = 8;
  localparam int unsigned BANK_AW_DEF  = 8;

  // one lane talks to one bank word
  localparam int unsigned LANE_DW = 32;
  localparam int unsigned LANE_BW = LANE_DW / 8;

  // full wide port
  localparam int unsigned WIDE_DW = NB_LANES * LANE_DW;
  localparam int unsigned WIDE_BW = WIDE_DW / 8;

  // request payload held in the FIFO
  // wen high means read, as on the TCDM bus
  typedef struct packed {
    logic               wen;
    logic [31:0]        add;
    logic [WIDE_BW-1:0] be;
    logic [WIDE_DW-1:0] data;
  } wide_req_t;

endpackage

//--- verilog/tcdm_if.sv
/* TCDM request/response port */

interface tcdm_if #(
  parameter int unsigned DW = 32
) ();

  localparam int unsigned BW = DW / 8;

  // request side, single cycle handshake on req and gnt
  logic          req;
  logic          gnt;
  logic          wen;
  logic [31:0]   add;
  logic [BW-1:0] be;
  logic [DW-1:0] data;

  // response side, r_valid one cycle after a granted read
  logic [DW-1:0] r_data;
  logic          r_valid;

  modport initiator (
    output req, wen, add, be, data,
    input  gnt, r_data, r_valid
  );

  modport target (
    input  req, wen, add, be, data,
    output gnt, r_data, r_valid
  );

endinterface

//--- verilog/req_fifo.sv
/* wide request FIFO */

module req_fifo import wide_mem_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  tcdm_if.target    tgt,
  tcdm_if.initiator ini
);

  // responses come back in request order, nothing to reorder
  assign tgt.r_data  = ini.r_data;
  assign tgt.r_valid = ini.r_valid;

  if (FIFO_DEPTH == 0) begin : g_pass
    assign ini.req  = tgt.req;
    assign ini.wen  = tgt.wen;
    assign ini.add  = tgt.add;
    assign ini.be   = tgt.be;
    assign ini.data = tgt.data;
    assign tgt.gnt  = ini.gnt;
  end else begin : g_fifo
    localparam int unsigned PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

    wide_req_t       fifo_q [FIFO_DEPTH];
    wide_req_t       push_d;
    wide_req_t       head;
    logic [PW-1:0]   wr_ptr_q;
    logic [PW-1:0]   rd_ptr_q;
    logic [CW-1:0]   count_q;
    logic            push;
    logic            pop;

    // grant only a live request, and only while there is room
    assign tgt.gnt = tgt.req & (count_q != CW'(FIFO_DEPTH));
    assign push    = tgt.req & tgt.gnt;
    assign pop     = ini.req & ini.gnt;

    assign push_d = '{wen: tgt.wen, add: tgt.add, be: tgt.be, data: tgt.data};

    // head entry is presented as the outgoing request
    assign head     = fifo_q[rd_ptr_q];
    assign ini.req  = (count_q != '0);
    assign ini.wen  = head.wen;
    assign ini.add  = head.add;
    assign ini.be   = head.be;
    assign ini.data = head.data;

    always_ff @(posedge clk_i) begin
      if (push) begin
        fifo_q[wr_ptr_q] <= push_d;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else if (clear_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        // pointers wrap at the depth, which need not be a power of two
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/lane_rotator.sv
/* lane to bank rotator */

module lane_rotator import wide_mem_pkg::*; #(
  parameter int unsigned NB_BANKS = NB_BANKS_DEF
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        en_i,
  input  logic [$clog2(NB_BANKS)-1:0] order_i,
  tcdm_if.target                      lanes [NB_LANES-1:0],
  tcdm_if.initiator                   banks [NB_BANKS-1:0]
);

  localparam int unsigned OW = $clog2(NB_BANKS);
  localparam int unsigned LW = $clog2(NB_LANES);

  logic [OW-1:0] order_q;

  // flattened copies so the mapping can use variable indices
  logic [NB_LANES-1:0]              lane_req;
  logic [NB_LANES-1:0]              lane_wen;
  logic [NB_LANES-1:0]              lane_gnt;
  logic [NB_LANES-1:0]              lane_rvalid;
  logic [NB_LANES-1:0][31:0]        lane_add;
  logic [NB_LANES-1:0][LANE_BW-1:0] lane_be;
  logic [NB_LANES-1:0][LANE_DW-1:0] lane_data;
  logic [NB_LANES-1:0][LANE_DW-1:0] lane_rdata;

  logic [NB_BANKS-1:0]              bank_req;
  logic [NB_BANKS-1:0]              bank_wen;
  logic [NB_BANKS-1:0]              bank_gnt;
  logic [NB_BANKS-1:0]              bank_rvalid;
  logic [NB_BANKS-1:0][31:0]        bank_add;
  logic [NB_BANKS-1:0][LANE_BW-1:0] bank_be;
  logic [NB_BANKS-1:0][LANE_DW-1:0] bank_data;
  logic [NB_BANKS-1:0][LANE_DW-1:0] bank_rdata;

  for (genvar i = 0; i < NB_LANES; i++) begin : g_lane
    assign lane_req[i]      = lanes[i].req;
    assign lane_wen[i]      = lanes[i].wen;
    assign lane_add[i]      = lanes[i].add;
    assign lane_be[i]       = lanes[i].be;
    assign lane_data[i]     = lanes[i].data;
    assign lanes[i].gnt     = lane_gnt[i];
    assign lanes[i].r_valid = lane_rvalid[i];
    assign lanes[i].r_data  = lane_rdata[i];
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    assign banks[b].req  = bank_req[b];
    assign banks[b].wen  = bank_wen[b];
    assign banks[b].add  = bank_add[b];
    assign banks[b].be   = bank_be[b];
    assign banks[b].data = bank_data[b];
    assign bank_gnt[b]    = banks[b].gnt;
    assign bank_rvalid[b] = banks[b].r_valid;
    assign bank_rdata[b]  = banks[b].r_data;
  end

  // bank b serves lane (b - order) mod NB_BANKS, if that lane exists
  always_comb begin : req_map
    logic [OW-1:0] sel;
    for (int b = 0; b < NB_BANKS; b++) begin
      sel = OW'(b) - order_i;
      // unused banks see an idle read
      bank_req[b]  = 1'b0;
      bank_wen[b]  = 1'b1;
      bank_add[b]  = '0;
      bank_be[b]   = '0;
      bank_data[b] = '0;
      if (int'(sel) < NB_LANES) begin
        bank_req[b]  = lane_req[sel[LW-1:0]];
        bank_wen[b]  = lane_wen[sel[LW-1:0]];
        bank_add[b]  = lane_add[sel[LW-1:0]];
        bank_be[b]   = lane_be[sel[LW-1:0]];
        bank_data[b] = lane_data[sel[LW-1:0]];
      end
    end
  end

  // grants follow the live order, read data the order seen at grant
  always_comb begin : rsp_map
    logic [OW-1:0] gnt_sel;
    logic [OW-1:0] rsp_sel;
    for (int i = 0; i < NB_LANES; i++) begin
      gnt_sel = order_i + OW'(i);
      rsp_sel = order_q + OW'(i);
      lane_gnt[i]    = bank_gnt[gnt_sel];
      lane_rvalid[i] = bank_rvalid[rsp_sel];
      lane_rdata[i]  = bank_rdata[rsp_sel];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
    end else if (clear_i) begin
      order_q <= '0;
    end else if (en_i) begin
      order_q <= order_i;
    end
  end

endmodule

//--- verilog/bank_router.sv
/* word-interleaved bank router */

module bank_router import wide_mem_pkg::*; #(
  parameter int unsigned NB_BANKS = NB_BANKS_DEF,
  parameter int unsigned BANK_AW  = BANK_AW_DEF
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  tcdm_if.target    wide,
  // one port per bank, after rotation
  tcdm_if.initiator lanes [NB_BANKS-1:0]
);

  localparam int unsigned OW = $clog2(NB_BANKS);
  // lowest address bit above the byte offset and bank select
  localparam int unsigned ROW_LSB = OW + 2;

  logic [OW-1:0]       bank_offset;
  logic [BANK_AW-1:0]  row_base;
  logic [NB_LANES-1:0] lane_gnt;
  logic                wide_gnt;
  logic                wide_gnt_q;

  // lane side of the rotator
  tcdm_if #(.DW(LANE_DW)) lane_if [NB_LANES-1:0] ();

  // bits [1:0] are a byte offset and play no part in routing
  assign bank_offset = wide.add[ROW_LSB-1:2];
  assign row_base    = wide.add[ROW_LSB+BANK_AW-1:ROW_LSB];

  for (genvar i = 0; i < NB_LANES; i++) begin : g_lane
    logic               wrap;
    logic [BANK_AW-1:0] row;

    // a lane past the last bank lands in the next row
    assign wrap = ({1'b0, bank_offset} + (OW+1)'(i)) >= (OW+1)'(NB_BANKS);
    assign row  = row_base + BANK_AW'(wrap);

    assign lane_if[i].req  = wide.req;
    assign lane_if[i].wen  = wide.wen;
    assign lane_if[i].add  = 32'({row, 2'b00});
    assign lane_if[i].be   = wide.be[i*LANE_BW +: LANE_BW];
    assign lane_if[i].data = wide.data[i*LANE_DW +: LANE_DW];

    assign lane_gnt[i] = lane_if[i].gnt;
    assign wide.r_data[i*LANE_DW +: LANE_DW] = lane_if[i].r_data;
  end

  // all banks in use must accept in the same cycle
  assign wide_gnt = wide.req & (&lane_gnt);
  assign wide.gnt = wide_gnt;

  // banks that granted during a stall repeat the access next cycle,
  // so only a response that follows a wide grant counts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wide_gnt_q <= 1'b0;
    end else if (clear_i) begin
      wide_gnt_q <= 1'b0;
    end else begin
      wide_gnt_q <= wide_gnt;
    end
  end

  // lane 0 stands for all, every lane answers in step
  assign wide.r_valid = lane_if[0].r_valid & wide_gnt_q;

  lane_rotator #(
    .NB_BANKS ( NB_BANKS )
  ) i_rotator (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .clear_i ( clear_i     ),
    .en_i    ( wide_gnt    ),
    .order_i ( bank_offset ),
    .lanes   ( lane_if     ),
    .banks   ( lanes       )
  );

endmodule

//--- verilog/sram_bank.sv
/* byte-writable SRAM bank */

module sram_bank import wide_mem_pkg::*; #(
  parameter int unsigned BANK_AW = BANK_AW_DEF
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   busy_i,
  tcdm_if.target port
);

  logic [LANE_DW-1:0] mem [2**BANK_AW];
  logic [BANK_AW-1:0] row;
  logic               wr_en;
  logic               rd_en;
  logic [LANE_DW-1:0] rdata_q;
  logic               rvalid_q;

  // another initiator holds the bank while busy
  assign port.gnt = ~busy_i;

  // word row within the bank
  assign row   = port.add[BANK_AW+1:2];
  assign wr_en = port.req & port.gnt & ~port.wen;
  assign rd_en = port.req & port.gnt & port.wen;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < LANE_BW; i++) begin
        if (port.be[i]) begin
          mem[row][i*8 +: 8] <= port.data[i*8 +: 8];
        end
      end
    end
    if (rd_en) begin
      rdata_q <= mem[row];
    end
  end

  // response flag, one cycle after a granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  assign port.r_data  = rdata_q;
  assign port.r_valid = rvalid_q;

endmodule

//--- verilog/wide_mem_top.sv
/* wide port memory subsystem */

module wide_mem_top import wide_mem_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 0,
  parameter int unsigned NB_BANKS   = NB_BANKS_DEF,
  parameter int unsigned BANK_AW    = BANK_AW_DEF
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  // wide request
  input  logic                req_i,
  input  logic                wen_i,
  input  logic [31:0]         add_i,
  input  logic [WIDE_BW-1:0]  be_i,
  input  logic [WIDE_DW-1:0]  wdata_i,
  output logic                gnt_o,
  // wide response
  output logic [WIDE_DW-1:0]  rdata_o,
  output logic                rvalid_o,
  // other initiators holding a bank
  input  logic [NB_BANKS-1:0] bank_busy_i
);

  tcdm_if #(.DW(WIDE_DW)) wide_if ();
  tcdm_if #(.DW(WIDE_DW)) post_fifo_if ();
  tcdm_if #(.DW(LANE_DW)) bank_if [NB_BANKS-1:0] ();

  assign wide_if.req  = req_i;
  assign wide_if.wen  = wen_i;
  assign wide_if.add  = add_i;
  assign wide_if.be   = be_i;
  assign wide_if.data = wdata_i;
  assign gnt_o        = wide_if.gnt;
  assign rdata_o      = wide_if.r_data;
  assign rvalid_o     = wide_if.r_valid;

  req_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .clear_i ( clear_i      ),
    .tgt     ( wide_if      ),
    .ini     ( post_fifo_if )
  );

  bank_router #(
    .NB_BANKS ( NB_BANKS ),
    .BANK_AW  ( BANK_AW  )
  ) i_router (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .clear_i ( clear_i      ),
    .wide    ( post_fifo_if ),
    .lanes   ( bank_if      )
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    sram_bank #(
      .BANK_AW ( BANK_AW )
    ) i_bank (
      .clk_i  ( clk_i          ),
      .rst_ni ( rst_ni         ),
      .busy_i ( bank_busy_i[b] ),
      .port   ( bank_if[b]     )
    );
  end

endmodule

//--- verif/wide_mem_checker.sv
/* wide port protocol checks */

module wide_mem_checker import wide_mem_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 0,
  parameter int unsigned NB_BANKS   = NB_BANKS_DEF
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                clear_i,
  input logic                req_i,
  input logic                wen_i,
  input logic [31:0]         add_i,
  input logic [WIDE_BW-1:0]  be_i,
  input logic [WIDE_DW-1:0]  wdata_i,
  input logic                gnt_i,
  input logic                rvalid_i,
  input logic [NB_BANKS-1:0] bank_busy_i,
  input logic [NB_BANKS-1:0] bank_req_i,
  input logic                route_gnt_i
);

  // granted reads still waiting for rvalid_o
  int rd_pending_q;
  int fail_cnt = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending_q <= 0;
    end else if (clear_i) begin
      rd_pending_q <= 0;
    end else begin
      rd_pending_q <= rd_pending_q + int'(req_i && gnt_i && wen_i) - int'(rvalid_i);
    end
  end

  rvalid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !rvalid_i)
    else begin
      $error("rvalid_o high during reset");
      fail_cnt++;
    end

  // a waiting request keeps all its fields
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable({wen_i, add_i, be_i, wdata_i}))
    else begin
      $error("request changed while waiting for gnt_o");
      fail_cnt++;
    end

  rsp_matched: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> rd_pending_q > 0)
    else begin
      $error("rvalid_o with no granted read outstanding");
      fail_cnt++;
    end

  // FIFO slots plus the one read in flight at the banks
  rd_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_pending_q <= int'(FIFO_DEPTH) + 1)
    else begin
      $error("too many reads outstanding");
      fail_cnt++;
    end

  // a busy bank in use holds back the whole wide access
  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    busy_blocks_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_req_i[b] && bank_busy_i[b] |-> !route_gnt_i)
      else begin
        $error("wide access granted while a bank in use was busy");
        fail_cnt++;
      end
  end

endmodule

bind wide_mem_top wide_mem_checker #(
  .FIFO_DEPTH ( FIFO_DEPTH ),
  .NB_BANKS   ( NB_BANKS   )
) chk_i (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .clear_i     ( clear_i     ),
  .req_i       ( req_i       ),
  .wen_i       ( wen_i       ),
  .add_i       ( add_i       ),
  .be_i        ( be_i        ),
  .wdata_i     ( wdata_i     ),
  .gnt_i       ( gnt_o       ),
  .rvalid_i    ( rvalid_o    ),
  .bank_busy_i ( bank_busy_i ),
  // requests seen by the eight banks
  .bank_req_i  ( {bank_if[7].req, bank_if[6].req, bank_if[5].req, bank_if[4].req,
                  bank_if[3].req, bank_if[2].req, bank_if[1].req, bank_if[0].req} ),
  // wide grant at the router, after the FIFO
  .route_gnt_i ( post_fifo_if.gnt )
);

//--- verif/wide_mem_tb.sv
/* wide memory testbench */

module wide_mem_tb import wide_mem_pkg::*; ();

  localparam int unsigned FIFO_DEPTH = 2;
  localparam int          TIMEOUT    = 200;
  localparam int          MEM_WORDS  = NB_BANKS_DEF * (2 ** BANK_AW_DEF);

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    clear;
  logic                    req;
  logic                    wen;
  logic [31:0]             add;
  logic [WIDE_BW-1:0]      be;
  logic [WIDE_DW-1:0]      wdata;
  logic                    gnt;
  logic [WIDE_DW-1:0]      rdata;
  logic                    rvalid;
  logic [NB_BANKS_DEF-1:0] bank_busy;

  logic [31:0]        lfsr_state;
  logic [7:0]         mem_model [MEM_WORDS*4];
  logic [WIDE_DW-1:0] exp_q [$];
  string              test_name;
  int                 test_errs;
  int                 total_errs;
  int                 tests_run;
  int                 tests_failed;
  logic               hung;
  logic               busy_mode;
  logic [31:0]        a;
  logic [WIDE_DW-1:0] d;

  always #2 clk = ~clk;

  wide_mem_top #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) dut_i (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .clear_i     ( clear     ),
    .req_i       ( req       ),
    .wen_i       ( wen       ),
    .add_i       ( add       ),
    .be_i        ( be        ),
    .wdata_i     ( wdata     ),
    .gnt_o       ( gnt       ),
    .rdata_o     ( rdata     ),
    .rvalid_o    ( rvalid    ),
    .bank_busy_i ( bank_busy )
  );

  // galois lfsr, one step per bit taken
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      val = {val[126:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // interleaved word index, lane i sits i words above the address
  function automatic int word_of(input logic [31:0] addr, input int lane);
    return (int'(addr >> 2) + lane) % MEM_WORDS;
  endfunction

  function automatic logic [WIDE_DW-1:0] model_read(input logic [31:0] addr);
    logic [WIDE_DW-1:0] val;
    for (int i = 0; i < NB_LANES; i++) begin
      for (int k = 0; k < LANE_BW; k++) begin
        val[(i*LANE_BW+k)*8 +: 8] = mem_model[word_of(addr, i)*LANE_BW + k];
      end
    end
    return val;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [WIDE_BW-1:0] mask,
                                      input logic [WIDE_DW-1:0] val);
    for (int i = 0; i < NB_LANES; i++) begin
      for (int k = 0; k < LANE_BW; k++) begin
        if (mask[i*LANE_BW+k]) begin
          mem_model[word_of(addr, i)*LANE_BW + k] = val[(i*LANE_BW+k)*8 +: 8];
        end
      end
    end
  endfunction

  task automatic step_busy();
    bank_busy = busy_mode ? NB_BANKS_DEF'(rand_bits(8) & rand_bits(8)) : '0;
  endtask

  // one wide request, held until granted
  task automatic send(input logic w, input logic [31:0] addr, input logic [WIDE_BW-1:0] mask,
                      input logic [WIDE_DW-1:0] val);
    int waited;
    if (hung) return;
    @(negedge clk);
    req   = 1'b1;
    wen   = w;
    add   = addr;
    be    = mask;
    wdata = val;
    step_busy();
    waited = 0;
    @(posedge clk);
    while (!gnt && waited < TIMEOUT) begin
      @(negedge clk);
      step_busy();
      @(posedge clk);
      waited++;
    end
    if (!gnt) begin
      $display("timeout: gnt_o never rose in test %s", test_name);
      hung = 1'b1;
    end else if (w) begin
      exp_q.push_back(model_read(addr));
    end else begin
      model_write(addr, mask, val);
    end
  endtask

  task automatic random_op();
    logic               w;
    logic [31:0]        addr;
    logic [WIDE_BW-1:0] mask;
    logic [WIDE_DW-1:0] val;
    w    = 1'(rand_bits(1));
    addr = 32'(rand_bits(32));
    mask = WIDE_BW'(rand_bits(16));
    val  = rand_bits(128);
    send(w, addr, mask, val);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  // idle the port, wait for the reads to drain, report the test
  task automatic finish_test();
    int waited;
    @(negedge clk);
    req       = 1'b0;
    busy_mode = 1'b0;
    bank_busy = '0;
    waited    = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT && !hung) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0 && !hung) begin
      $display("timeout: %0d read responses missing in test %s", exp_q.size(), test_name);
      hung = 1'b1;
    end
    tests_run++;
    if (test_errs != 0 || hung) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d mismatches", test_name,
             (test_errs == 0 && !hung) ? "passed" : "FAILED", test_errs);
    total_errs += test_errs;
  endtask

  // responses come back in request order
  always @(posedge clk) begin : check_rsp
    logic [WIDE_DW-1:0] exp;
    if (rst_n && rvalid) begin
      assert (exp_q.size() != 0) else begin
        $display("read response arrived with no read outstanding in test %s", test_name);
        test_errs++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        assert (rdata === exp) else begin
          $display("Fail %s: expected %h, actual %h", test_name, exp, rdata);
          test_errs++;
        end
      end
    end
  end

  initial begin : main
    rst_n        = 1'b1;
    clear        = 1'b0;
    req          = 1'b0;
    wen          = 1'b1;
    add          = '0;
    be           = '0;
    wdata        = '0;
    bank_busy    = '0;
    busy_mode    = 1'b0;
    hung         = 1'b0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = 32'hf504_69ee;
    #1 rst_n = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_idle");
    repeat (16) @(negedge clk);
    finish_test();

    // fill pattern covers every word, each value tied to its word index
    start_test("aligned");
    for (int j = 0; j < MEM_WORDS / NB_LANES; j++) begin
      for (int i = 0; i < NB_LANES; i++) begin
        d[i*LANE_DW +: LANE_DW] = (32'(j*NB_LANES + i) * 32'h0001_0001) ^ 32'h5a5a_c3c3;
      end
      send(1'b0, 32'(j * WIDE_BW), '1, d);
    end
    a = 32'(rand_bits(32)) & ~32'h1f;
    send(1'b0, a, '1, rand_bits(128));
    send(1'b1, a, '0, '0);
    finish_test();

    // offset 5, lanes 3 lands on bank 0 of the next row
    start_test("wrap");
    a = (32'(rand_bits(32)) & ~32'h1f) | 32'h17;
    send(1'b0, a, '1, rand_bits(128));
    send(1'b1, a, '0, '0);
    send(1'b1, a & ~32'h1f, '0, '0);
    send(1'b1, (a & ~32'h1f) + 32'h20, '0, '0);
    finish_test();

    start_test("partial");
    a = 32'(rand_bits(32));
    send(1'b0, a, 16'h0a51, rand_bits(128));
    send(1'b1, a, '0, '0);
    send(1'b0, a + 32'h8, 16'h8402, rand_bits(128));
    send(1'b1, a, '0, '0);
    finish_test();

    start_test("busy_stream");
    busy_mode = 1'b1;
    for (int n = 0; n < 60; n++) begin
      random_op();
    end
    finish_test();

    start_test("random_mix");
    for (int n = 0; n < 400; n++) begin
      random_op();
    end
    finish_test();

    $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
             tests_run, tests_failed, total_errs, dut_i.chk_i.fail_cnt);
    if (tests_failed == 0 && total_errs == 0 && dut_i.chk_i.fail_cnt == 0 && !hung) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/wide_mem_pkg.sv
verilog/tcdm_if.sv
verilog/req_fifo.sv
verilog/lane_rotator.sv
verilog/bank_router.sv
verilog/sram_bank.sv
verilog/wide_mem_top.sv
verif/wide_mem_checker.sv
verif/wide_mem_tb.sv

//--- Makefile
# Verilator simulation of the wide memory subsystem

VERILATOR ?= verilator
TOP       ?= wide_mem_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
	  echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
